// ==== verilog/core_pkg.sv ====
/* core package
   shared widths, instruction encodings and the fetch queue entry type */
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [XLEN-1:0] instr_t;
	// boot word index, the reset pc is four times this value
	typedef logic [9:0] boot_idx_t;

	// addi x0, x0, 0
	localparam instr_t NOP = 32'h0000_0013;
	localparam instr_t EBREAK = 32'h0010_0073;

	// memory hands back words little endian
	localparam logic MEM_BIG_ENDIAN = 1'b0;

	// instruction queue sizing, almost full leaves room for one read in flight
	localparam int QUEUE_DEPTH_LOG2 = 4;
	localparam int QUEUE_ALMOST_FULL = 13;

	// raw memory word together with the address it came from
	typedef struct packed {
		data_t instr;
		data_t pc;
	} fetch_entry_t;

	// reverse the four bytes of a word
	function automatic data_t swap_bytes(input data_t word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

endpackage

`default_nettype wire

// ==== verilog/axil_pkg.sv ====
/* AXI4-Lite package
   read channel payloads, response codes and the instruction prot value */
`default_nettype none

package axil_pkg;

	// AR payload
	typedef struct packed {
		core_pkg::data_t addr;
		logic [2:0] prot;
	} axil_ar_t;

	// R payload
	typedef struct packed {
		core_pkg::data_t data;
		logic [1:0] resp;
	} axil_r_t;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_t;

	// unprivileged, secure, instruction access
	localparam logic [2:0] AXIL_PROT_INSTR = 3'b100;

endpackage

`default_nettype wire

// ==== verilog/fetch_pc_gen.sv ====
/* fetch PC generator
   owns the PC, tracks the read in flight and runs the halt/fetch/pause/break FSM */
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen (
	input wire clk,
	input wire rst_n,
	input wire go,
	input wire core_pkg::boot_idx_t boot_pc,
	input wire flush,
	input wire core_pkg::data_t redirect_pc,
	input wire core_pkg::instr_t retired_instr,
	input wire almost_full,
	input wire fetch_ack,
	input wire fetch_done,
	input wire core_pkg::data_t fetch_data,
	output logic fetch_req,
	output core_pkg::data_t fetch_addr,
	output logic push,
	output core_pkg::fetch_entry_t push_entry
);

	import core_pkg::*;

	typedef enum logic [1:0] {
		HALT,
		FETCH,
		PAUSE,
		BREAK_WAIT
	} state_t;

	state_t state_q, state_d;
	data_t pc;
	logic outstanding;
	logic flush_pending;
	logic req_taken;
	logic keep_word;
	logic ebreak_hit;
	instr_t core_word;

	assign req_taken = fetch_req && fetch_ack;

	// a completion is kept unless the read it belongs to was flushed
	assign keep_word = fetch_done && !flush_pending && !flush;

	assign core_word = MEM_BIG_ENDIAN ? fetch_data : swap_bytes(fetch_data);
	assign ebreak_hit = keep_word && (core_word == EBREAK);

	// one read at a time, and only while fetching
	assign fetch_req = (state_q == FETCH) && !outstanding;
	assign fetch_addr = pc;

	assign push = keep_word;
	assign push_entry = '{instr: fetch_data, pc: pc};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
		end else if (req_taken) begin
			outstanding <= 1'b1;
		end else if (fetch_done) begin
			outstanding <= 1'b0;
		end
	end

	// read on the bus that no longer matches the program flow
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_pending <= 1'b0;
		end else if (fetch_done) begin
			flush_pending <= 1'b0;
		end else if (flush && (outstanding || req_taken)) begin
			flush_pending <= 1'b1;
		end
	end

	// pc holds the address of the read in flight until it completes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= data_t'({boot_pc, 2'b00});
		end else if (flush) begin
			pc <= redirect_pc;
		end else if (keep_word) begin
			pc <= pc + 32'd4;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			HALT: begin
				if (go) begin
					state_d = FETCH;
				end
			end
			FETCH, PAUSE: begin
				if (ebreak_hit) begin
					state_d = BREAK_WAIT;
				end else if (almost_full) begin
					state_d = PAUSE;
				end else begin
					state_d = FETCH;
				end
			end
			BREAK_WAIT: begin
				// a redirect means the ebreak was on a dead path
				if (flush) begin
					state_d = FETCH;
				end else if (retired_instr == EBREAK) begin
					state_d = HALT;
				end
			end
			default: begin
				state_d = HALT;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= HALT;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/axil_read_master.sv ====
/* AXI4-Lite read master
   issues one AR per fetch request and returns the R data with a done pulse */
`timescale 1ns/10ps
`default_nettype none

module axil_read_master (
	input wire clk,
	input wire rst_n,
	input wire fetch_req,
	input wire core_pkg::data_t fetch_addr,
	input wire arready,
	input wire rvalid,
	input wire axil_pkg::axil_r_t r,
	output logic fetch_ack,
	output axil_pkg::axil_ar_t ar,
	output logic arvalid,
	output logic rready,
	output logic fetch_done,
	output core_pkg::data_t fetch_data
);

	import axil_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		RESP
	} state_t;

	state_t state;
	logic r_taken;

	assign fetch_ack = (state == IDLE);
	assign arvalid = (state == ADDR);
	assign rready = (state == RESP);
	assign r_taken = rvalid && rready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (fetch_req) begin
						state <= ADDR;
					end
				end
				ADDR: begin
					if (arready) begin
						state <= RESP;
					end
				end
				RESP: begin
					if (rvalid) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// address stays stable while arvalid waits for arready
	always_ff @(posedge clk) begin
		if (fetch_req && fetch_ack) begin
			ar <= '{addr: fetch_addr, prot: AXIL_PROT_INSTR};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= r_taken;
		end
	end

	// response code is not checked
	always_ff @(posedge clk) begin
		if (r_taken) begin
			fetch_data <= r.data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/instr_queue.sv ====
/* instruction queue
   flushable circular FIFO of fetch entries with a registered head */
`timescale 1ns/10ps
`default_nettype none

module instr_queue (
	input wire clk,
	input wire rst_n,
	input wire flush,
	input wire push,
	input wire core_pkg::fetch_entry_t push_entry,
	input wire pop,
	output core_pkg::fetch_entry_t head,
	output logic empty,
	output logic almost_full
);

	import core_pkg::*;

	fetch_entry_t mem [2**QUEUE_DEPTH_LOG2];
	logic [QUEUE_DEPTH_LOG2-1:0] wr_ptr;
	logic [QUEUE_DEPTH_LOG2-1:0] rd_ptr;
	logic [QUEUE_DEPTH_LOG2:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	// count reaches its top bit only when every slot is taken
	assign full = count[QUEUE_DEPTH_LOG2];
	assign empty = (count == '0);
	assign almost_full = (count >= QUEUE_ALMOST_FULL);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	// head is valid the cycle after pop
	always_ff @(posedge clk) begin
		if (do_pop) begin
			head <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/instr_issue.sv ====
/* instruction issue
   pops the queue in order and presents the instruction in core byte order */
`timescale 1ns/10ps
`default_nettype none

module instr_issue (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire flush,
	input wire empty,
	input wire core_pkg::fetch_entry_t head,
	output logic pop,
	output core_pkg::instr_t instr,
	output core_pkg::data_t pc_out,
	output logic instr_valid
);

	import core_pkg::*;

	instr_t head_instr;

	// decode takes a new instruction whenever it is not stalled
	assign pop = !empty && !stall;

	// valid trails pop by one cycle to match the registered queue read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_valid <= 1'b0;
		end else if (flush) begin
			instr_valid <= 1'b0;
		end else if (!stall) begin
			instr_valid <= pop;
		end
	end

	assign head_instr = MEM_BIG_ENDIAN ? head.instr : swap_bytes(head.instr);

	// idle slots show a nop at pc zero
	assign instr = instr_valid ? head_instr : NOP;
	assign pc_out = instr_valid ? head.pc : '0;

endmodule

`default_nettype wire

// ==== verilog/fetch_axil.sv ====
/* instruction fetch front end
   PC generator, AXI4-Lite read master, instruction queue and issue stage */
`timescale 1ns/10ps
`default_nettype none

module fetch_axil (
	input wire clk,
	input wire rst_n,
	// core side
	input wire go,
	input wire core_pkg::boot_idx_t boot_pc,
	input wire stall,
	input wire flush,
	input wire core_pkg::data_t redirect_pc,
	input wire core_pkg::instr_t retired_instr,
	output core_pkg::instr_t instr,
	output core_pkg::data_t pc_out,
	output logic instr_valid,
	// AXI4-Lite read channels
	output axil_pkg::axil_ar_t ar,
	output logic arvalid,
	input wire arready,
	input wire axil_pkg::axil_r_t r,
	input wire rvalid,
	output logic rready
);

	import core_pkg::*;

	logic fetch_req;
	logic fetch_ack;
	logic fetch_done;
	data_t fetch_addr;
	data_t fetch_data;
	logic push;
	logic pop;
	logic empty;
	logic almost_full;
	fetch_entry_t push_entry;
	fetch_entry_t head;

	fetch_pc_gen u_pc_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.go            (go),
		.boot_pc       (boot_pc),
		.flush         (flush),
		.redirect_pc   (redirect_pc),
		.retired_instr (retired_instr),
		.almost_full   (almost_full),
		.fetch_ack     (fetch_ack),
		.fetch_done    (fetch_done),
		.fetch_data    (fetch_data),
		.fetch_req     (fetch_req),
		.fetch_addr    (fetch_addr),
		.push          (push),
		.push_entry    (push_entry)
	);

	axil_read_master u_read_master (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.arready    (arready),
		.rvalid     (rvalid),
		.r          (r),
		.fetch_ack  (fetch_ack),
		.ar         (ar),
		.arvalid    (arvalid),
		.rready     (rready),
		.fetch_done (fetch_done),
		.fetch_data (fetch_data)
	);

	instr_queue u_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (flush),
		.push        (push),
		.push_entry  (push_entry),
		.pop         (pop),
		.head        (head),
		.empty       (empty),
		.almost_full (almost_full)
	);

	instr_issue u_issue (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.flush       (flush),
		.empty       (empty),
		.head        (head),
		.pop         (pop),
		.instr       (instr),
		.pc_out      (pc_out),
		.instr_valid (instr_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_axil.sv ====
/* testbench for the instruction fetch front end
   AXI4-Lite memory model, directed tests and compare tasks */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_axil;

	import core_pkg::*;
	import axil_pkg::*;

	localparam int MEM_WORDS = 1024;
	// the tests need roughly 700 cycles with the slowest bus delays
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int STALL_CYCLES = 200;
	localparam boot_idx_t BOOT_IDX = 10'd64;
	localparam data_t BRANCH_PC = 32'h0000_0400;
	localparam data_t BREAK_BASE = 32'h0000_0800;
	localparam data_t EBREAK_PC = 32'h0000_080c;
	// AxPROT bit 2 marks an instruction access, unprivileged and secure
	localparam logic [2:0] PROT_INSTR_ACCESS = 3'b100;

	logic clk;
	logic rst_n;
	logic go;
	boot_idx_t boot_pc;
	logic stall;
	logic flush;
	data_t redirect_pc;
	instr_t retired_instr;
	instr_t instr;
	data_t pc_out;
	logic instr_valid;
	axil_ar_t ar;
	logic arvalid;
	logic arready;
	axil_r_t r;
	logic rvalid;
	logic rready;

	// memory words as stored in little endian order
	data_t mem [MEM_WORDS];
	logic [31:0] rng;
	data_t next_pc;
	int cycle_count;
	int check_count;
	int err_count;

	fetch_axil u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.go            (go),
		.boot_pc       (boot_pc),
		.stall         (stall),
		.flush         (flush),
		.redirect_pc   (redirect_pc),
		.retired_instr (retired_instr),
		.instr         (instr),
		.pc_out        (pc_out),
		.instr_valid   (instr_valid),
		.ar            (ar),
		.arvalid       (arvalid),
		.arready       (arready),
		.r             (r),
		.rvalid        (rvalid),
		.rready        (rready)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_instr(input string name, input instr_t got, input instr_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_pc(input string name, input data_t got, input data_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_prot(input string name, input logic [2:0] got, input logic [2:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			rng = lcg_next(rng);
			mem[i] = rng;
			// keep random words from decoding as a stray ebreak
			if (mem[i] == swap_bytes(EBREAK)) begin
				mem[i] = ~mem[i];
			end
		end
		mem[EBREAK_PC[11:2]] = swap_bytes(EBREAK);
	endtask

	// AXI4-Lite slave with random AR and R delays of 0 to 3 cycles
	initial begin : axil_slave
		logic [1:0] delay;
		data_t rd_addr;
		logic taken;
		forever begin
			@(negedge clk);
			if (arvalid === 1'b1) begin
				rng = lcg_next(rng);
				delay = rng[17:16];
				repeat (delay) @(negedge clk);
				rd_addr = ar.addr;
				check_prot("ar.prot", ar.prot, PROT_INSTR_ACCESS);
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				// the read is outstanding from here until R completes
				check_valid("rready", rready, 1'b1);
				rng = lcg_next(rng);
				delay = rng[19:18];
				repeat (delay) @(negedge clk);
				r = '{data: mem[rd_addr[11:2]], resp: OKAY};
				rvalid = 1'b1;
				do begin
					taken = rready;
					@(negedge clk);
				end while (!taken);
				rvalid = 1'b0;
			end
		end
	end

	// waits for the next newly issued instruction and checks it against memory
	task automatic expect_issue();
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			if (instr_valid && !stall) begin
				seen = 1'b1;
			end
		end
		check_pc("pc_out", pc_out, next_pc);
		check_instr("instr", instr, swap_bytes(mem[next_pc[11:2]]));
		next_pc = next_pc + 32'd4;
	endtask

	task automatic expect_run(input int count);
		for (int i = 0; i < count; i++) begin
			expect_issue();
		end
	endtask

	task automatic apply_redirect(input data_t target);
		flush = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		flush = 1'b0;
		check_valid("instr_valid", instr_valid, 1'b0);
		check_pc("pc_out", pc_out, '0);
		next_pc = target;
	endtask

	task automatic reset_idle();
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_valid("instr_valid", instr_valid, 1'b0);
			check_instr("instr", instr, NOP);
			check_pc("pc_out", pc_out, '0);
			check_valid("arvalid", arvalid, 1'b0);
			check_valid("rready", rready, 1'b0);
		end
	endtask

	task automatic sequential_fetch();
		next_pc = data_t'({BOOT_IDX, 2'b00});
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		expect_run(8);
	endtask

	task automatic stall_backpressure();
		instr_t held_instr;
		data_t held_pc;
		logic held_valid;
		expect_issue();
		held_instr = instr;
		held_pc = pc_out;
		held_valid = instr_valid;
		stall = 1'b1;
		for (int i = 0; i < STALL_CYCLES; i++) begin
			@(negedge clk);
			check_instr("instr", instr, held_instr);
			check_pc("pc_out", pc_out, held_pc);
			check_valid("instr_valid", instr_valid, held_valid);
			// the queue is full well before the window ends
			if (i >= STALL_CYCLES - 40) begin
				check_valid("arvalid", arvalid, 1'b0);
			end
		end
		stall = 1'b0;
		expect_run(16);
	endtask

	task automatic branch_redirect();
		apply_redirect(BRANCH_PC);
		expect_run(6);
	endtask

	task automatic ebreak_halt();
		apply_redirect(BREAK_BASE);
		expect_run(3);
		expect_issue();
		check_instr("instr", instr, EBREAK);
		repeat (20) begin
			@(negedge clk);
			check_valid("arvalid", arvalid, 1'b0);
			check_valid("instr_valid", instr_valid, 1'b0);
		end
		retired_instr = EBREAK;
		@(negedge clk);
		retired_instr = '0;
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		expect_run(3);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		go = 1'b0;
		boot_pc = BOOT_IDX;
		stall = 1'b0;
		flush = 1'b0;
		redirect_pc = '0;
		retired_instr = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		cycle_count = 0;
		check_count = 0;
		err_count = 0;
		rng = 32'h9c6e_4ab0;
		fill_memory();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_idle();
		sequential_fetch();
		stall_backpressure();
		branch_redirect();
		ebreak_halt();
		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetch_axil.f ====
verilog/core_pkg.sv
verilog/axil_pkg.sv
verilog/fetch_pc_gen.sv
verilog/axil_read_master.sv
verilog/instr_queue.sv
verilog/instr_issue.sv
verilog/fetch_axil.sv
testbench/tb_fetch_axil.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP ?= tb_fetch_axil
LINT_TOP ?= fetch_axil
FILELIST ?= fetch_axil.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --timescale 1ns/10ps -j 0
PASS_MSG ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
